// File: Bender.yml
package:
  name: tomasulo_core

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - tomasulo_pkg.sv
      - rename_table.sv
      - reservation_station.sv
      - integer_unit.sv
      - tomasulo_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_tomasulo_core.sv

// File: integer_unit.sv
`timescale 1ns/10ps

`include "tomasulo_core_consts.svh"

module integer_unit (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        flush,
    input  logic                        issue_valid,
    input  tomasulo_pkg::issue_packet_t issue,
    output tomasulo_pkg::cdb_packet_t   cdb,
    output logic                        busy
);

    localparam int SHIFT_W = $clog2(`TC_WORD_WIDTH);

    logic                        s1_valid;
    tomasulo_pkg::issue_packet_t s1_packet;
    tomasulo_pkg::word_t         result;
    logic                        cdb_valid;
    tomasulo_pkg::tag_t          cdb_tag;
    tomasulo_pkg::word_t         cdb_value;

    ////////////////////////////////////////////////////////////
    // Stage 2 datapath
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (s1_packet.op)
            `TC_OP_ADD: result = s1_packet.a + s1_packet.b;
            `TC_OP_SUB: result = s1_packet.a - s1_packet.b;
            `TC_OP_AND: result = s1_packet.a & s1_packet.b;
            `TC_OP_OR:  result = s1_packet.a | s1_packet.b;
            `TC_OP_XOR: result = s1_packet.a ^ s1_packet.b;
            `TC_OP_SLL: result = s1_packet.a << s1_packet.b[SHIFT_W-1:0];
            // Low word of the product
            `TC_OP_MUL: result = s1_packet.a * s1_packet.b;
            default:    result = s1_packet.b;
        endcase
    end

    // Valid bits, flush drops both stages
    always_ff @(posedge clock) begin
        if (reset || flush) begin
            s1_valid  <= 1'b0;
            cdb_valid <= 1'b0;
        end else begin
            s1_valid  <= issue_valid;
            cdb_valid <= s1_valid;
        end
    end

    always_ff @(posedge clock) begin
        s1_packet <= issue;
        cdb_tag   <= s1_packet.tag;
        cdb_value <= result;
    end

    assign cdb  = '{valid: cdb_valid, tag: cdb_tag, value: cdb_value};
    assign busy = s1_valid || cdb_valid;

endmodule

// File: rename_table.sv
`timescale 1ns/10ps

`include "tomasulo_core_consts.svh"

module rename_table (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           flush,
    input  logic                           dispatch_valid,
    input  tomasulo_pkg::dispatch_packet_t dispatch,
    input  tomasulo_pkg::tag_t             alloc_tag,
    input  tomasulo_pkg::cdb_packet_t      cdb,
    output tomasulo_pkg::operand_t         src_a,
    output tomasulo_pkg::operand_t         src_b,
    input  tomasulo_pkg::reg_idx_t         read_idx,
    output tomasulo_pkg::word_t            read_value
);

    tomasulo_pkg::word_t [`TC_REG_COUNT-1:0] reg_value;
    tomasulo_pkg::tag_t  [`TC_REG_COUNT-1:0] producer;

    // Bus result turns a pending source into a present one
    function automatic tomasulo_pkg::operand_t lookup(
        input tomasulo_pkg::reg_idx_t    idx,
        input tomasulo_pkg::tag_t        tag,
        input tomasulo_pkg::word_t       value,
        input tomasulo_pkg::cdb_packet_t bus
    );
        tomasulo_pkg::operand_t result;
        result.tag   = tag;
        result.value = value;
        if (idx == '0) begin
            result.tag   = `TC_ZERO_TAG;
            result.value = '0;
        end else if (tag != `TC_ZERO_TAG && bus.valid && bus.tag == tag) begin
            result.tag   = `TC_ZERO_TAG;
            result.value = bus.value;
        end
        return result;
    endfunction

    ////////////////////////////////////////////////////////////
    // Operand lookup
    ////////////////////////////////////////////////////////////

    assign src_a = lookup(dispatch.rs1, producer[dispatch.rs1], reg_value[dispatch.rs1], cdb);
    assign src_b = lookup(dispatch.rs2, producer[dispatch.rs2], reg_value[dispatch.rs2], cdb);

    // Register 0 is never written, so it stays zero
    assign read_value = reg_value[read_idx];

    ////////////////////////////////////////////////////////////
    // Write-back and renaming
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            reg_value <= '0;
            producer  <= '0;
        end else if (flush) begin
            // Speculative producers vanish, values stay
            producer <= '0;
        end else begin
            for (int i = 1; i < `TC_REG_COUNT; i++) begin
                if (cdb.valid && producer[i] != `TC_ZERO_TAG && producer[i] == cdb.tag) begin
                    reg_value[i] <= cdb.value;
                    producer[i]  <= `TC_ZERO_TAG;
                end
            end
            // Younger producer overrides a same-cycle write-back
            if (dispatch_valid && dispatch.rd != '0) begin
                producer[dispatch.rd] <= alloc_tag;
            end
        end
    end

    a_zero_reg_no_producer: assert property (
        @(posedge clock) disable iff (reset)
        producer[0] == `TC_ZERO_TAG
    ) else $error("register 0 received a producer tag");

endmodule

// File: reservation_station.sv
`timescale 1ns/10ps

`include "tomasulo_core_consts.svh"

module reservation_station (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           flush,
    input  logic                           dispatch_valid,
    input  tomasulo_pkg::dispatch_packet_t dispatch,
    input  tomasulo_pkg::operand_t         src_a,
    input  tomasulo_pkg::operand_t         src_b,
    input  tomasulo_pkg::cdb_packet_t      cdb,
    output tomasulo_pkg::tag_t             alloc_tag,
    output logic                           rs_full,
    output logic                           issue_valid,
    output tomasulo_pkg::issue_packet_t    issue,
    output logic                           entries_busy
);

    localparam int DEPTH  = `TC_RS_DEPTH;
    localparam int SLOT_W = $clog2(DEPTH);

    // Slot index, also the relative age where 0 is the oldest
    typedef logic [SLOT_W-1:0] slot_t;

    typedef struct packed {
        logic                ready;
        tomasulo_pkg::tag_t  tag;
        tomasulo_pkg::word_t value;
    } rs_operand_t;

    typedef struct packed {
        logic                  busy;
        logic                  issued;
        tomasulo_pkg::alu_op_t op;
        rs_operand_t           a;
        rs_operand_t           b;
        slot_t                 age;
    } rs_entry_t;

    rs_entry_t [DEPTH-1:0] entry;
    rs_entry_t             new_entry;

    logic [DEPTH-1:0] busy;
    logic [DEPTH-1:0] ready;
    logic [DEPTH-1:0] free_match;
    logic [DEPTH-1:0] wait_match;
    logic [DEPTH:0]   tag_live;
    logic             dispatch_accept;
    logic             alloc_found;
    logic             free_found;
    slot_t            alloc_slot;
    slot_t            issue_slot;
    slot_t            free_slot;
    int unsigned      busy_count;

    // Source capture with bypass from the bus in the same cycle
    function automatic rs_operand_t capture(
        input tomasulo_pkg::operand_t    src,
        input tomasulo_pkg::cdb_packet_t bus
    );
        rs_operand_t result;
        result.ready = (src.tag == `TC_ZERO_TAG);
        result.tag   = src.tag;
        result.value = src.value;
        if (!result.ready && bus.valid && bus.tag == src.tag) begin
            result.ready = 1'b1;
            result.value = bus.value;
        end
        return result;
    endfunction

    ////////////////////////////////////////////////////////////
    // Allocation, selection and freeing
    ////////////////////////////////////////////////////////////

    always_comb begin
        alloc_found = 1'b0;
        alloc_slot  = '0;
        issue_valid = 1'b0;
        issue_slot  = '0;
        free_found  = 1'b0;
        free_slot   = '0;
        busy_count  = 0;
        tag_live[0] = 1'b0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            busy[i]         = entry[i].busy;
            ready[i]        = entry[i].busy && !entry[i].issued && entry[i].a.ready
                              && entry[i].b.ready;
            free_match[i]   = cdb.valid && entry[i].busy
                              && cdb.tag == tomasulo_pkg::tag_t'(i + 1);
            tag_live[i + 1] = entry[i].busy && entry[i].issued;
            // Descending loop leaves the lowest free slot
            if (!entry[i].busy) begin
                alloc_found = 1'b1;
                alloc_slot  = slot_t'(i);
            end
            if (entry[i].busy) begin
                busy_count++;
            end
            if (free_match[i]) begin
                free_found = 1'b1;
                free_slot  = slot_t'(i);
            end
        end
        // Oldest ready entry has the smallest age
        for (int i = 0; i < DEPTH; i++) begin
            if (ready[i] && (!issue_valid || entry[i].age < entry[issue_slot].age)) begin
                issue_valid = 1'b1;
                issue_slot  = slot_t'(i);
            end
        end
    end

    // Waiting operands that name the tag about to be handed out
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            wait_match[i] = entry[i].busy
                            && ((!entry[i].a.ready && entry[i].a.tag == alloc_tag)
                                || (!entry[i].b.ready && entry[i].b.tag == alloc_tag));
        end
    end

    assign rs_full         = &busy;
    assign entries_busy    = |busy;
    assign dispatch_accept = dispatch_valid && !rs_full;
    assign alloc_tag       = alloc_found ? tomasulo_pkg::tag_t'(alloc_slot + 1) : `TC_ZERO_TAG;

    assign issue.op  = entry[issue_slot].op;
    assign issue.a   = entry[issue_slot].a.value;
    assign issue.b   = entry[issue_slot].b.value;
    assign issue.tag = tomasulo_pkg::tag_t'(issue_slot + 1);

    always_comb begin
        new_entry.busy   = 1'b1;
        new_entry.issued = 1'b0;
        new_entry.op     = dispatch.op;
        // Count of older entries that stay
        new_entry.age    = slot_t'(busy_count - (free_found ? 1 : 0));
        new_entry.a      = capture(src_a, cdb);
        new_entry.b      = capture(src_b, cdb);
        if (dispatch.op == `TC_OP_LI) begin
            new_entry.a = '{ready: 1'b1, tag: `TC_ZERO_TAG, value: '0};
        end
        if (dispatch.op == `TC_OP_LI || dispatch.rs2 == '0) begin
            new_entry.b = '{ready: 1'b1, tag: `TC_ZERO_TAG, value: dispatch.imm};
        end
    end

    ////////////////////////////////////////////////////////////
    // Entry state
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            for (int i = 0; i < DEPTH; i++) begin
                entry[i].busy   <= 1'b0;
                entry[i].issued <= 1'b0;
            end
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (entry[i].busy) begin
                    // Wake-up
                    if (cdb.valid && !entry[i].a.ready && entry[i].a.tag == cdb.tag) begin
                        entry[i].a.ready <= 1'b1;
                        entry[i].a.value <= cdb.value;
                    end
                    if (cdb.valid && !entry[i].b.ready && entry[i].b.tag == cdb.tag) begin
                        entry[i].b.ready <= 1'b1;
                        entry[i].b.value <= cdb.value;
                    end
                    if (free_found && entry[i].age > entry[free_slot].age) begin
                        entry[i].age <= entry[i].age - 1'b1;
                    end
                end
                if (free_match[i]) begin
                    entry[i].busy   <= 1'b0;
                    entry[i].issued <= 1'b0;
                end
            end
            if (issue_valid) begin
                entry[issue_slot].issued <= 1'b1;
            end
            if (dispatch_accept) begin
                entry[alloc_slot] <= new_entry;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    a_no_dispatch_when_full: assert property (
        @(posedge clock) disable iff (reset)
        dispatch_valid |-> !rs_full
    ) else $error("dispatch strobe while the station is full");

    // Broadcast tag must belong to an entry already sent to the unit
    a_cdb_names_live_entry: assert property (
        @(posedge clock) disable iff (reset)
        cdb.valid |-> tag_live[cdb.tag]
    ) else $error("bus tag names a free or unissued entry");

    // A new tag must have one owner only, so no operand may still wait on it
    a_single_tag_owner: assert property (
        @(posedge clock) disable iff (reset)
        dispatch_accept |-> !(|wait_match)
    ) else $error("new tag is still awaited by a waiting operand");

endmodule

// File: tb_tomasulo_core.sv
`timescale 1ns/10ps

`include "tomasulo_core_consts.svh"

module tb_tomasulo_core;

    localparam int CLOCK_PERIOD   = 8;
    localparam int DRIVE_DELAY    = 1;
    localparam int RESET_CYCLES   = 5;
    localparam int CYCLES_PER_CMD = 40;

    logic                           clock = 1'b0;
    logic                           reset;
    logic                           flush;
    logic                           dispatch_valid;
    tomasulo_pkg::dispatch_packet_t dispatch;
    tomasulo_pkg::reg_idx_t         read_idx;
    tomasulo_pkg::word_t            read_value;
    logic                           rs_full;
    logic                           idle;
    tomasulo_pkg::cdb_packet_t      cdb;

    // Golden registers in program order, and their copy at the last drain
    tomasulo_pkg::word_t gold_regs [`TC_REG_COUNT];
    tomasulo_pkg::word_t drained_regs [`TC_REG_COUNT];

    logic [8*120-1:0]    commands [$];
    integer              seed;
    int                  watchdog_cycles;
    int                  full_stalls;
    int                  latency_wait;
    tomasulo_pkg::word_t latency_value;

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    tomasulo_core i_tomasulo_core (
        .clock          (clock),
        .reset          (reset),
        .flush          (flush),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .read_idx       (read_idx),
        .read_value     (read_value),
        .rs_full        (rs_full),
        .idle           (idle),
        .cdb            (cdb)
    );

    ////////////////////////////////////////////////////////////
    // Checks and reference model
    ////////////////////////////////////////////////////////////

    task automatic check_value(
        input logic [`TC_WORD_WIDTH-1:0] actual,
        input logic [`TC_WORD_WIDTH-1:0] expected,
        input string                     what
    );
        if (actual !== expected) begin
            $display("Error at time %0t: %0s is %h, expected %h", $time, what, actual,
                     expected);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic tomasulo_pkg::word_t expected_result(
        input tomasulo_pkg::alu_op_t op,
        input tomasulo_pkg::word_t   a,
        input tomasulo_pkg::word_t   b
    );
        case (op)
            `TC_OP_ADD: return a + b;
            `TC_OP_SUB: return a - b;
            `TC_OP_AND: return a & b;
            `TC_OP_OR:  return a | b;
            `TC_OP_XOR: return a ^ b;
            `TC_OP_SLL: return a << (b % `TC_WORD_WIDTH);
            `TC_OP_MUL: return a * b;
            default:    return b;
        endcase
    endfunction

    // Bus must stay quiet, then show the LI value in the third cycle
    always @(negedge clock) begin
        if (latency_wait != 0) begin
            latency_wait = latency_wait - 1;
            if (latency_wait == 0) begin
                check_value(cdb.valid, 1'b1, "bus valid three cycles after an LI");
                check_value(cdb.value, latency_value, "bus value of the LI");
                // Empty station hands out entry 0 and tag 1
                check_value(cdb.tag, 1, "bus tag of the LI");
            end else begin
                check_value(cdb.valid, 1'b0, "bus valid before the third cycle");
            end
        end
    end

    initial begin
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge clock);
        $display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    ////////////////////////////////////////////////////////////
    // Command tasks
    ////////////////////////////////////////////////////////////

    task automatic dispatch_op(
        input tomasulo_pkg::alu_op_t  op,
        input tomasulo_pkg::reg_idx_t rd,
        input tomasulo_pkg::reg_idx_t rs1,
        input tomasulo_pkg::reg_idx_t rs2,
        input tomasulo_pkg::word_t    imm
    );
        tomasulo_pkg::word_t a;
        tomasulo_pkg::word_t b;
        while (rs_full) begin
            full_stalls++;
            @(posedge clock);
            #DRIVE_DELAY;
        end
        if (idle && op == `TC_OP_LI) begin
            latency_wait  = 4;
            latency_value = imm;
        end
        dispatch_valid = 1'b1;
        dispatch.op    = op;
        dispatch.rd    = rd;
        dispatch.rs1   = rs1;
        dispatch.rs2   = rs2;
        dispatch.imm   = imm;
        a = gold_regs[rs1];
        b = (op == `TC_OP_LI || rs2 == '0) ? imm : gold_regs[rs2];
        if (rd != '0) begin
            gold_regs[rd] = expected_result(op, a, b);
        end
        @(posedge clock);
        #DRIVE_DELAY;
        dispatch_valid = 1'b0;
    endtask

    task automatic dispatch_random(input int count);
        tomasulo_pkg::reg_idx_t rd;
        tomasulo_pkg::word_t    imm;
        repeat (count) begin
            rd  = 1 + ($unsigned($random(seed)) % (`TC_REG_COUNT - 1));
            imm = $random(seed);
            dispatch_op(`TC_OP_LI, rd, '0, '0, imm);
        end
    endtask

    task automatic flush_core();
        flush = 1'b1;
        @(posedge clock);
        #DRIVE_DELAY;
        flush     = 1'b0;
        gold_regs = drained_regs;
        check_value(idle, 1'b1, "idle after flush");
    endtask

    task automatic read_register(
        input  tomasulo_pkg::reg_idx_t idx,
        output tomasulo_pkg::word_t    value
    );
        read_idx = idx;
        @(negedge clock);
        value = read_value;
        @(posedge clock);
        #DRIVE_DELAY;
    endtask

    task automatic check_register(input int idx, input tomasulo_pkg::word_t expected);
        tomasulo_pkg::word_t value;
        check_value(gold_regs[idx], expected, $sformatf("model of register %0d", idx));
        read_register(idx, value);
        check_value(value, expected, $sformatf("register %0d", idx));
    endtask

    // Wait for an empty core, then compare every register with the model
    task automatic drain_and_compare();
        tomasulo_pkg::word_t value;
        while (!idle) begin
            @(posedge clock);
            #DRIVE_DELAY;
        end
        for (int r = 0; r < `TC_REG_COUNT; r++) begin
            read_register(r, value);
            check_value(value, gold_regs[r], $sformatf("register %0d after drain", r));
        end
        drained_regs = gold_regs;
    endtask

    task automatic reject_line(input logic [8*120-1:0] text);
        $display("Malformed command in the input file: %0s", text);
        $display("Simulation failed");
        $fatal(1, "bad command");
    endtask

    task automatic run_command(input logic [8*120-1:0] text);
        byte                 cmd;
        int                  fields;
        int                  f_op;
        int                  f_rd;
        int                  f_rs1;
        int                  f_rs2;
        tomasulo_pkg::word_t f_imm;
        fields = $sscanf(text, " %c", cmd);
        case (cmd)
            "D": begin
                fields = $sscanf(text, " %c %h %h %h %h %h", cmd, f_op, f_rd, f_rs1, f_rs2,
                                 f_imm);
                if (fields != 6) begin
                    reject_line(text);
                end
                dispatch_op(f_op, f_rd, f_rs1, f_rs2, f_imm);
            end
            "C": begin
                fields = $sscanf(text, " %c %h %h", cmd, f_rd, f_imm);
                if (fields != 3) begin
                    reject_line(text);
                end
                check_register(f_rd, f_imm);
            end
            "R": begin
                fields = $sscanf(text, " %c %h", cmd, f_rd);
                if (fields != 2) begin
                    reject_line(text);
                end
                dispatch_random(f_rd);
            end
            "F": flush_core();
            "W": drain_and_compare();
            default: reject_line(text);
        endcase
    endtask

    task automatic load_commands();
        int               fd;
        byte              cmd;
        logic [8*120-1:0] text;
        fd = $fopen("tomasulo_core_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open tomasulo_core_input.txt for reading");
            $display("Simulation failed");
            $fatal(1, "missing input file");
        end
        while (!$feof(fd)) begin
            text = '0;
            if ($fgets(text, fd) != 0) begin
                // Blank lines and comment lines are dropped
                if ($sscanf(text, " %c", cmd) == 1 && cmd != "#") begin
                    commands.push_back(text);
                end
            end
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        reset           = 1'b1;
        flush           = 1'b0;
        dispatch_valid  = 1'b0;
        dispatch        = '0;
        read_idx        = '0;
        seed            = 84372;
        full_stalls     = 0;
        latency_wait    = 0;
        latency_value   = '0;
        watchdog_cycles = 0;
        for (int r = 0; r < `TC_REG_COUNT; r++) begin
            gold_regs[r]    = '0;
            drained_regs[r] = '0;
        end
        load_commands();
        watchdog_cycles = commands.size() * CYCLES_PER_CMD + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clock);
        #DRIVE_DELAY;
        reset = 1'b0;
        check_value(idle, 1'b1, "idle after reset");
        check_value(rs_full, 1'b0, "full after reset");
        check_value(cdb.valid, 1'b0, "bus valid after reset");
        foreach (commands[i]) begin
            run_command(commands[i]);
        end
        // The MUL-blocked burst has to stall at least once
        check_value(full_stalls != 0, 1'b1, "station full seen");
        $display("Simulation passed");
        $finish;
    end

endmodule

// File: tomasulo_core.f
+incdir+.
tomasulo_pkg.sv
rename_table.sv
reservation_station.sv
integer_unit.sv
tomasulo_core.sv
tb_tomasulo_core.sv

// File: tomasulo_core.sv
`timescale 1ns/10ps

module tomasulo_core (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           flush,
    input  logic                           dispatch_valid,
    input  tomasulo_pkg::dispatch_packet_t dispatch,
    input  tomasulo_pkg::reg_idx_t         read_idx,
    output tomasulo_pkg::word_t            read_value,
    output logic                           rs_full,
    output logic                           idle,
    output tomasulo_pkg::cdb_packet_t      cdb
);

    tomasulo_pkg::operand_t      src_a;
    tomasulo_pkg::operand_t      src_b;
    tomasulo_pkg::tag_t          alloc_tag;
    tomasulo_pkg::issue_packet_t issue;
    logic                        issue_valid;
    logic                        entries_busy;
    logic                        unit_busy;
    logic                        dispatch_accept;

    // Strobes during full never rename
    assign dispatch_accept = dispatch_valid && !rs_full;

    rename_table i_rename_table (
        .clock          (clock),
        .reset          (reset),
        .flush          (flush),
        .dispatch_valid (dispatch_accept),
        .dispatch       (dispatch),
        .alloc_tag      (alloc_tag),
        .cdb            (cdb),
        .src_a          (src_a),
        .src_b          (src_b),
        .read_idx       (read_idx),
        .read_value     (read_value)
    );

    reservation_station i_reservation_station (
        .clock          (clock),
        .reset          (reset),
        .flush          (flush),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .src_a          (src_a),
        .src_b          (src_b),
        .cdb            (cdb),
        .alloc_tag      (alloc_tag),
        .rs_full        (rs_full),
        .issue_valid    (issue_valid),
        .issue          (issue),
        .entries_busy   (entries_busy)
    );

    integer_unit i_integer_unit (
        .clock       (clock),
        .reset       (reset),
        .flush       (flush),
        .issue_valid (issue_valid),
        .issue       (issue),
        .cdb         (cdb),
        .busy        (unit_busy)
    );

    assign idle = !(entries_busy || unit_busy);

endmodule

// File: tomasulo_core_consts.svh
`ifndef TOMASULO_CORE_CONSTS_SVH
`define TOMASULO_CORE_CONSTS_SVH

////////////////////////////////////////////////////////////
// Core sizes
////////////////////////////////////////////////////////////

// Architectural registers, register 0 reads as zero
`define TC_REG_COUNT  16
// Reservation station entries, works from 2 to 8
`define TC_RS_DEPTH   4
`define TC_WORD_WIDTH 32

////////////////////////////////////////////////////////////
// Operation codes
////////////////////////////////////////////////////////////

`define TC_OP_ADD 3'd0
`define TC_OP_SUB 3'd1
`define TC_OP_AND 3'd2
`define TC_OP_OR  3'd3
`define TC_OP_XOR 3'd4
`define TC_OP_SLL 3'd5
`define TC_OP_MUL 3'd6
// Result is the immediate
`define TC_OP_LI  3'd7

// Tag meaning the value is present
`define TC_ZERO_TAG '0

`endif

// File: tomasulo_core_input.txt
# D op rd rs1 rs2 imm | C reg value | R count | F flush | W drain (all fields hex)
# op codes: 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 sll, 6 mul, 7 li
D 7 1 0 0 00000005
D 7 2 0 0 00000007
D 0 3 1 2 00000000
D 0 4 3 3 00000000
D 0 5 4 0 00000100
W
C 1 00000005
C 3 0000000c
C 5 00000118
# MUL feeds SUB feeds XOR
D 7 6 0 0 00001234
D 6 7 6 6 00000000
D 1 8 7 6 00000000
D 4 9 8 1 00000000
W
C 7 014b5a90
C 9 014b4859
# r10 renamed twice, the older ADD broadcasts last
D 6 b 9 2 00000000
D 0 a b 0 00000001
D 7 a 0 0 0000abcd
W
C a 0000abcd
C b 090efa6f
# Station fills behind a MUL chain
D 6 c 2 2 00000000
D 6 c c c 00000000
D 0 d c 0 00000001
D 0 e c 0 00000002
D 1 f c 2 00000000
D 4 d c 1 00000000
D 5 e e 0 00000004
W
C d 00000964
C e 00009630
C f 0000095a
# Flush one cycle after a dispatch
D 0 1 1 0 00000010
F
W
C 1 00000005
R 6
W
R 8
W

// File: tomasulo_pkg.sv
`include "tomasulo_core_consts.svh"

package tomasulo_pkg;

    ////////////////////////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////////////////////////

    typedef logic [`TC_WORD_WIDTH-1:0]          word_t;
    typedef logic [$clog2(`TC_REG_COUNT)-1:0]   reg_idx_t;
    // Station index plus one, zero is reserved
    typedef logic [$clog2(`TC_RS_DEPTH+1)-1:0]  tag_t;
    typedef logic [2:0]                         alu_op_t;

    ////////////////////////////////////////////////////////////
    // Packets between the stages
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        alu_op_t  op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        word_t    imm;
    } dispatch_packet_t;

    // One source operand as seen in the rename table
    typedef struct packed {
        tag_t  tag;
        word_t value;
    } operand_t;

    typedef struct packed {
        alu_op_t op;
        word_t   a;
        word_t   b;
        tag_t    tag;
    } issue_packet_t;

    // Common data bus
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        word_t value;
    } cdb_packet_t;

endpackage
